// File: Makefile
# Verilator flow for the vector dispatch stage

VERILATOR ?= verilator
TOP       ?= tb_rvv_dispatch
RTL_TOP   ?= rvv_dispatch
FILELIST  ?= files.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  := PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/tb_clk_gen.sv
`timescale 1ns/100ps
// Testbench clock and reset generator
// Free running clock and an active low reset released a fixed number of cycles in

module tb_clk_gen #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Released just after an edge, like the rest of the stimulus
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// File: dv/tb_rvv_dispatch.sv
`timescale 1ns/100ps
// Testbench for the dual-issue vector dispatch stage
// Drives random uops, ROB state and station readies with forced corner cases,
// models the VRF, and checks the DUT against a reference of the issue rules

module tb_rvv_dispatch
    import rvv_dispatch_pkg::*;
();

    localparam int VLEN        = 128;
    localparam int ROB_DEPTH   = 8;
    localparam int ROB_IDX_W   = $clog2(ROB_DEPTH);
    localparam int CLK_PERIOD  = 20;
    localparam int RST_CYCLES  = 10;
    localparam int TEST_CYCLES = 200;
    localparam int NUM_TESTS   = 5;
    // Reset, all tests and some slack
    localparam int RUN_CYCLES  = RST_CYCLES + NUM_TESTS * TEST_CYCLES + 50;

    localparam int T_RANDOM   = 0;
    localparam int T_ROB_RAW  = 1;
    localparam int T_UOP_RAW  = 2;
    localparam int T_STRUCT   = 3;
    localparam int T_BACKPRES = 4;

    logic                                   clk;
    logic                                   rst_n;
    logic       [NUM_DP_UOP-1:0]            uop_valid;
    uop_class_e [NUM_DP_UOP-1:0]            uop_class;
    exe_unit_e  [NUM_DP_UOP-1:0]            uop_exe_unit;
    funct_t     [NUM_DP_UOP-1:0]            uop_funct;
    vreg_idx_t  [NUM_DP_UOP-1:0]            uop_vs1;
    vreg_idx_t  [NUM_DP_UOP-1:0]            uop_vs2;
    vreg_idx_t  [NUM_DP_UOP-1:0]            uop_vd;
    logic       [NUM_DP_UOP-1:0]            uop_vd_valid;
    logic       [NUM_DP_UOP-1:0]            uop_ready;
    logic       [NUM_DP_UOP-1:0]            rs_ready_alu;
    logic       [NUM_DP_UOP-1:0]            rs_ready_mul;
    logic       [NUM_DP_UOP-1:0]            rs_ready_lsu;
    logic       [NUM_DP_UOP-1:0]            rs_valid_alu;
    logic       [NUM_DP_UOP-1:0]            rs_valid_mul;
    logic       [NUM_DP_UOP-1:0]            rs_valid_lsu;
    funct_t     [NUM_DP_UOP-1:0]            rs_funct;
    logic       [NUM_DP_UOP-1:0][ROB_IDX_W-1:0] rs_rob_index;
    logic       [NUM_DP_UOP-1:0][VLEN-1:0]  rs_vs1_data;
    logic       [NUM_DP_UOP-1:0][VLEN-1:0]  rs_vs2_data;
    logic       [NUM_DP_UOP-1:0][VLEN-1:0]  rs_vd_data;
    logic       [NUM_DP_UOP-1:0]            rob_push_valid;
    vreg_idx_t  [NUM_DP_UOP-1:0]            rob_push_vd;
    logic       [NUM_DP_UOP-1:0]            rob_push_vd_valid;
    logic       [NUM_DP_UOP-1:0]            rob_push_ready;
    logic       [ROB_IDX_W-1:0]             rob_index;
    logic       [ROB_DEPTH-1:0]             rob_valid;
    vreg_idx_t  [ROB_DEPTH-1:0]             rob_w_index;
    logic       [ROB_DEPTH-1:0]             rob_w_valid;
    logic       [ROB_DEPTH-1:0][VLEN-1:0]   rob_w_data;
    vreg_idx_t  [NUM_VRF_RD-1:0]            vrf_rd_index;
    logic       [NUM_VRF_RD-1:0][VLEN-1:0]  vrf_rd_data;

    // Reference model results with source slot 0 as vs2, 1 as vs1 and 2 as vd
    logic      [NUM_DP_UOP-1:0][2:0]           exp_mask;
    logic      [NUM_DP_UOP-1:0][2:0][VLEN-1:0] exp_src;
    logic      [NUM_DP_UOP-1:0]                exp_rob_haz;
    logic      [NUM_DP_UOP-1:0]                exp_sel_rdy;
    logic      [NUM_DP_UOP-1:0]                exp_issue;
    logic      [NUM_DP_UOP-1:0]                exp_alu;
    logic      [NUM_DP_UOP-1:0]                exp_mul;
    logic      [NUM_DP_UOP-1:0]                exp_lsu;
    logic      [NUM_DP_UOP-1:0][ROB_IDX_W-1:0] exp_rob_idx;
    logic      [NUM_DP_UOP-1:0]                opnd_ok;
    logic                                      exp_strct;
    logic                                      exp_uu;
    vreg_idx_t [NUM_VRF_RD-1:0]                exp_rd_index;

    logic [31:0] rng_state;
    int          err_hs;
    int          err_payload;
    int          err_port;
    int          err_opnd;

    tb_clk_gen #(
        .PERIOD     (CLK_PERIOD),
        .RST_CYCLES (RST_CYCLES)
    ) u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rvv_dispatch #(
        .VLEN      (VLEN),
        .ROB_DEPTH (ROB_DEPTH)
    ) u_dut (.*);

    function automatic logic [31:0] xorshift(logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // Bits {vd, vs1, vs2} that a class reads
    function automatic logic [2:0] src_mask(uop_class_e c);
        case (c)
            VVV:     return 3'b111;
            XVV:     return 3'b011;
            VVX:     return 3'b110;
            VXX:     return 3'b100;
            XVX:     return 3'b010;
            XXV:     return 3'b001;
            default: return 3'b000;
        endcase
    endfunction

    // VRF contents are the register index repeated over the whole vector
    function automatic logic [VLEN-1:0] vrf_word(vreg_idx_t idx);
        logic [VLEN-1:0] w;
        for (int b = 0; b < VLEN; b++) begin
            w[b] = idx[b % REG_INDEX_WIDTH];
        end
        return w;
    endfunction

    // ROB result is the entry number repeated with the top bit set to mark bypass data
    function automatic logic [VLEN-1:0] rob_word(int e);
        logic [VLEN-1:0]      w;
        logic [ROB_IDX_W-1:0] n;
        n = ROB_IDX_W'(e);
        for (int b = 0; b < VLEN; b++) begin
            w[b] = n[b % ROB_IDX_W];
        end
        w[VLEN-1] = 1'b1;
        return w;
    endfunction

    always_comb begin
        for (int p = 0; p < NUM_VRF_RD; p++) begin
            vrf_rd_data[p] = vrf_word(vrf_rd_index[p]);
        end
    end

    // Reference model of operand lookup, port packing and issue
    always_comb begin
        int        pos;
        vreg_idx_t idx;
        logic      found;
        logic      pend;
        pos          = 0;
        exp_rd_index = '0;
        for (int i = 0; i < NUM_DP_UOP; i++) begin
            exp_mask[i]    = src_mask(uop_class[i]);
            exp_rob_haz[i] = 1'b0;
            for (int s = 0; s < 3; s++) begin
                idx = (s == 0) ? uop_vs2[i] : (s == 1) ? uop_vs1[i] : uop_vd[i];
                exp_src[i][s] = vrf_word(idx);
                found = 1'b0;
                pend  = 1'b0;
                // Youngest entry first
                for (int e = ROB_DEPTH - 1; e >= 0; e--) begin
                    if (!found && rob_valid[e] && (rob_w_index[e] == idx)) begin
                        found = 1'b1;
                        if (rob_w_valid[e]) begin
                            exp_src[i][s] = rob_word(e);
                        end else begin
                            pend = 1'b1;
                        end
                    end
                end
                if (exp_mask[i][s]) begin
                    exp_rob_haz[i] = exp_rob_haz[i] | pend;
                    if (pos < NUM_VRF_RD) begin
                        exp_rd_index[pos] = idx;
                    end
                    pos++;
                end
            end
            case (uop_exe_unit[i])
                EXE_ALU: exp_sel_rdy[i] = rs_ready_alu[i];
                EXE_MUL: exp_sel_rdy[i] = rs_ready_mul[i];
                EXE_LSU: exp_sel_rdy[i] = rs_ready_lsu[i];
                default: exp_sel_rdy[i] = 1'b0;
            endcase
            exp_rob_idx[i] = ROB_IDX_W'((int'(rob_index) + i) % ROB_DEPTH);
        end
        exp_strct = pos > NUM_VRF_RD;
        exp_uu = uop_vd_valid[0] &&
                 ((exp_mask[1][0] && (uop_vs2[1] == uop_vd[0])) ||
                  (exp_mask[1][1] && (uop_vs1[1] == uop_vd[0])) ||
                  (exp_mask[1][2] && (uop_vd[1] == uop_vd[0])));
        exp_issue[0] = uop_valid[0] && !exp_rob_haz[0] && exp_sel_rdy[0] &&
                       rob_push_ready[0];
        exp_issue[1] = exp_issue[0] && uop_valid[1] && !exp_rob_haz[1] && !exp_strct &&
                       !exp_uu && exp_sel_rdy[1] && rob_push_ready[1];
        for (int i = 0; i < NUM_DP_UOP; i++) begin
            exp_alu[i] = exp_issue[i] && (uop_exe_unit[i] == EXE_ALU);
            exp_mul[i] = exp_issue[i] && (uop_exe_unit[i] == EXE_MUL);
            exp_lsu[i] = exp_issue[i] && (uop_exe_unit[i] == EXE_LSU);
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_DP_UOP; i++) begin
            opnd_ok[i] = !exp_issue[i] ||
                         ((!exp_mask[i][0] || (rs_vs2_data[i] == exp_src[i][0])) &&
                          (!exp_mask[i][1] || (rs_vs1_data[i] == exp_src[i][1])) &&
                          (!exp_mask[i][2] || (rs_vd_data[i] == exp_src[i][2])));
        end
    end

    a_handshake: assert property (@(negedge clk) disable iff (!rst_n)
        (uop_ready == exp_issue) && (rob_push_valid == exp_issue) &&
        (rs_valid_alu == exp_alu) && (rs_valid_mul == exp_mul) && (rs_valid_lsu == exp_lsu))
        else begin
            err_hs++;
            $display("Error at %0t ns: uop_ready %b rob_push_valid %b, expected %b",
                     $time, uop_ready, rob_push_valid, exp_issue);
        end

    a_payload: assert property (@(negedge clk) disable iff (!rst_n)
        (!exp_issue[0] || (rs_rob_index[0] == exp_rob_idx[0])) &&
        (!exp_issue[1] || (rs_rob_index[1] == exp_rob_idx[1])) &&
        (rs_funct == uop_funct) && (rob_push_vd == uop_vd) &&
        (rob_push_vd_valid == uop_vd_valid))
        else begin
            err_payload++;
            $display("Error at %0t ns: payload rob index %h, expected %h",
                     $time, rs_rob_index, exp_rob_idx);
        end

    a_ports: assert property (@(negedge clk) disable iff (!rst_n)
        vrf_rd_index == exp_rd_index)
        else begin
            err_port++;
            $display("Error at %0t ns: vrf_rd_index %h, expected %h",
                     $time, vrf_rd_index, exp_rd_index);
        end

    a_operands: assert property (@(negedge clk) disable iff (!rst_n)
        &opnd_ok)
        else begin
            err_opnd++;
            $display("Error at %0t ns: operand data wrong for issued uops, ok bits %b",
                     $time, opnd_ok);
        end

    // One cycle of random stimulus with the corner case of the given test forced on top
    task automatic drive_cycle(input int test);
        logic [31:0] r;
        for (int i = 0; i < NUM_DP_UOP; i++) begin
            r = next_rand();
            uop_valid[i]    = r[2:0] != 3'd0;
            uop_class[i]    = uop_class_e'(3'(r[10:3] % 7));
            uop_exe_unit[i] = exe_unit_e'(2'(r[12:11] % 3));
            uop_funct[i]    = r[18:13];
            // Small register range so that matches are common
            uop_vs1[i]      = vreg_idx_t'(r[21:19]);
            uop_vs2[i]      = vreg_idx_t'(r[24:22]);
            uop_vd[i]       = vreg_idx_t'(r[27:25]);
            uop_vd_valid[i] = r[28];
        end
        for (int e = 0; e < ROB_DEPTH; e++) begin
            r = next_rand();
            rob_w_index[e] = vreg_idx_t'(r[2:0]);
        end
        r = next_rand();
        rob_index      = r[ROB_IDX_W-1:0];
        rob_valid      = r[8 +: ROB_DEPTH];
        rob_w_valid    = r[16 +: ROB_DEPTH] | r[24 +: ROB_DEPTH];
        rs_ready_alu   = '1;
        rs_ready_mul   = '1;
        rs_ready_lsu   = '1;
        rob_push_ready = '1;
        r = next_rand();
        case (test)
            // Plain random traffic with nothing forced
            T_RANDOM: begin
            end
            T_ROB_RAW: begin
                uop_class[0] = XVV;
                uop_class[1] = XVV;
                rob_valid[ROB_DEPTH-1]   = 1'b1;
                rob_w_valid[ROB_DEPTH-1] = 1'b0;
                rob_w_index[ROB_DEPTH-1] = r[0] ? uop_vs2[0] : uop_vs2[1];
            end
            T_UOP_RAW: begin
                uop_vd_valid[0] = 1'b1;
                uop_vs1[1]      = uop_vd[0];
                uop_class[1]    = XVX;
            end
            // Two or three reads each so that totals of four, five and six all occur
            T_STRUCT: begin
                uop_class[0] = r[0] ? VVV : VVX;
                uop_class[1] = r[1] ? VVV : XVV;
            end
            T_BACKPRES: begin
                rs_ready_alu   = r[1:0];
                rs_ready_mul   = r[3:2];
                rs_ready_lsu   = r[5:4];
                rob_push_ready = r[7:6];
            end
        endcase
    endtask

    initial begin
        rng_state      = 32'h8beb94a7;
        err_hs         = 0;
        err_payload    = 0;
        err_port       = 0;
        err_opnd       = 0;
        uop_valid      = '0;
        uop_class      = {XXX, XXX};
        uop_exe_unit   = {EXE_ALU, EXE_ALU};
        uop_funct      = '0;
        uop_vs1        = '0;
        uop_vs2        = '0;
        uop_vd         = '0;
        uop_vd_valid   = '0;
        rs_ready_alu   = '0;
        rs_ready_mul   = '0;
        rs_ready_lsu   = '0;
        rob_push_ready = '0;
        rob_index      = '0;
        rob_valid      = '0;
        rob_w_index    = '0;
        rob_w_valid    = '0;
        for (int e = 0; e < ROB_DEPTH; e++) begin
            rob_w_data[e] = rob_word(e);
        end
        @(posedge rst_n);
        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int c = 0; c < TEST_CYCLES; c++) begin
                @(posedge clk);
                #1;
                drive_cycle(t);
            end
        end
        @(posedge clk);
        #1;
        uop_valid = '0;
        @(negedge clk);
        @(posedge clk);
        $display("Errors: handshake %0d, payload %0d, ports %0d, operands %0d",
                 err_hs, err_payload, err_port, err_opnd);
        if (err_hs + err_payload + err_port + err_opnd == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("Watchdog: the run did not finish within %0d cycles", RUN_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: files.f
src/rvv_dispatch_pkg.sv
src/rvv_dispatch_operand.sv
src/rvv_dispatch_vrf_read.sv
src/rvv_dispatch_ctrl.sv
src/rvv_dispatch.sv
dv/tb_clk_gen.sv
dv/tb_rvv_dispatch.sv

// File: src/rvv_dispatch.sv
`timescale 1ns/100ps
// Dual-issue dispatch stage of the vector backend
// Takes up to two uops per cycle from the uop queue, resolves their operands
// from the VRF or from completed ROB entries, and issues them in order to the
// ALU, MUL and LSU reservation stations while pushing them to the ROB

module rvv_dispatch
    import rvv_dispatch_pkg::*;
#(
    parameter int VLEN      = 128,
    parameter int ROB_DEPTH = 8
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic       [NUM_DP_UOP-1:0]           uop_valid,
    input  uop_class_e [NUM_DP_UOP-1:0]           uop_class,
    input  exe_unit_e  [NUM_DP_UOP-1:0]           uop_exe_unit,
    input  funct_t     [NUM_DP_UOP-1:0]           uop_funct,
    input  vreg_idx_t  [NUM_DP_UOP-1:0]           uop_vs1,
    input  vreg_idx_t  [NUM_DP_UOP-1:0]           uop_vs2,
    input  vreg_idx_t  [NUM_DP_UOP-1:0]           uop_vd,
    input  logic       [NUM_DP_UOP-1:0]           uop_vd_valid,
    output logic       [NUM_DP_UOP-1:0]           uop_ready,
    input  logic       [NUM_DP_UOP-1:0]           rs_ready_alu,
    input  logic       [NUM_DP_UOP-1:0]           rs_ready_mul,
    input  logic       [NUM_DP_UOP-1:0]           rs_ready_lsu,
    output logic       [NUM_DP_UOP-1:0]           rs_valid_alu,
    output logic       [NUM_DP_UOP-1:0]           rs_valid_mul,
    output logic       [NUM_DP_UOP-1:0]           rs_valid_lsu,
    output funct_t     [NUM_DP_UOP-1:0]           rs_funct,
    output logic       [NUM_DP_UOP-1:0][$clog2(ROB_DEPTH)-1:0] rs_rob_index,
    output logic       [NUM_DP_UOP-1:0][VLEN-1:0] rs_vs1_data,
    output logic       [NUM_DP_UOP-1:0][VLEN-1:0] rs_vs2_data,
    output logic       [NUM_DP_UOP-1:0][VLEN-1:0] rs_vd_data,
    output logic       [NUM_DP_UOP-1:0]           rob_push_valid,
    output vreg_idx_t  [NUM_DP_UOP-1:0]           rob_push_vd,
    output logic       [NUM_DP_UOP-1:0]           rob_push_vd_valid,
    input  logic       [NUM_DP_UOP-1:0]           rob_push_ready,
    input  logic       [$clog2(ROB_DEPTH)-1:0]    rob_index,
    input  logic       [ROB_DEPTH-1:0]            rob_valid,
    input  vreg_idx_t  [ROB_DEPTH-1:0]            rob_w_index,
    input  logic       [ROB_DEPTH-1:0]            rob_w_valid,
    input  logic       [ROB_DEPTH-1:0][VLEN-1:0]  rob_w_data,
    output vreg_idx_t  [NUM_VRF_RD-1:0]           vrf_rd_index,
    input  logic       [NUM_VRF_RD-1:0][VLEN-1:0] vrf_rd_data
);

    localparam int ROB_IDX_W = $clog2(ROB_DEPTH);
    localparam int SUM_W     = ROB_IDX_W + 1;

    logic [NUM_DP_UOP-1:0]           raw_hazard;
    logic                            strct_hazard;
    logic [NUM_DP_UOP-1:0][VLEN-1:0] vrf_vs1_data;
    logic [NUM_DP_UOP-1:0][VLEN-1:0] vrf_vs2_data;
    logic [NUM_DP_UOP-1:0][VLEN-1:0] vrf_vd_data;

    rvv_dispatch_vrf_read #(
        .VLEN (VLEN)
    ) u_vrf_read (
        .clk          (clk),
        .rst_n        (rst_n),
        .uop_class    (uop_class),
        .uop_vs1      (uop_vs1),
        .uop_vs2      (uop_vs2),
        .uop_vd       (uop_vd),
        .vrf_rd_data  (vrf_rd_data),
        .vrf_rd_index (vrf_rd_index),
        .strct_hazard (strct_hazard),
        .vrf_vs1_data (vrf_vs1_data),
        .vrf_vs2_data (vrf_vs2_data),
        .vrf_vd_data  (vrf_vd_data)
    );

    for (genvar i = 0; i < NUM_DP_UOP; i++) begin : g_uop
        logic [SUM_W-1:0] idx_sum;

        rvv_dispatch_operand #(
            .VLEN      (VLEN),
            .ROB_DEPTH (ROB_DEPTH)
        ) u_operand (
            .uop_class    (uop_class[i]),
            .uop_vs1      (uop_vs1[i]),
            .uop_vs2      (uop_vs2[i]),
            .uop_vd       (uop_vd[i]),
            .rob_valid    (rob_valid),
            .rob_w_index  (rob_w_index),
            .rob_w_valid  (rob_w_valid),
            .rob_w_data   (rob_w_data),
            .vrf_vs1_data (vrf_vs1_data[i]),
            .vrf_vs2_data (vrf_vs2_data[i]),
            .vrf_vd_data  (vrf_vd_data[i]),
            .raw_hazard   (raw_hazard[i]),
            .vs1_data     (rs_vs1_data[i]),
            .vs2_data     (rs_vs2_data[i]),
            .vd_data      (rs_vd_data[i])
        );

        // Uop i takes the i-th free ROB entry, wrapping at the ROB depth
        assign idx_sum         = {1'b0, rob_index} + SUM_W'(i);
        assign rs_rob_index[i] = (idx_sum >= SUM_W'(ROB_DEPTH)) ?
                                 ROB_IDX_W'(idx_sum - SUM_W'(ROB_DEPTH)) :
                                 idx_sum[ROB_IDX_W-1:0];

        assign rs_funct[i]          = uop_funct[i];
        assign rob_push_vd[i]       = uop_vd[i];
        assign rob_push_vd_valid[i] = uop_vd_valid[i];
    end

    rvv_dispatch_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .uop_valid      (uop_valid),
        .uop_exe_unit   (uop_exe_unit),
        .uop_class      (uop_class),
        .uop_vs1        (uop_vs1),
        .uop_vs2        (uop_vs2),
        .uop_vd         (uop_vd),
        .uop_vd_valid   (uop_vd_valid),
        .raw_hazard     (raw_hazard),
        .strct_hazard   (strct_hazard),
        .rs_ready_alu   (rs_ready_alu),
        .rs_ready_mul   (rs_ready_mul),
        .rs_ready_lsu   (rs_ready_lsu),
        .rob_push_ready (rob_push_ready),
        .uop_ready      (uop_ready),
        .rs_valid_alu   (rs_valid_alu),
        .rs_valid_mul   (rs_valid_mul),
        .rs_valid_lsu   (rs_valid_lsu),
        .rob_push_valid (rob_push_valid)
    );

endmodule

// File: src/rvv_dispatch_ctrl.sv
`timescale 1ns/100ps
// Issue control for the dual-issue dispatch stage
// Checks the younger uop against the older one for RAW, applies the in-order
// issue rules and drives the valid/ready handshakes towards the uop queue,
// the ALU, MUL and LSU reservation stations and the ROB

module rvv_dispatch_ctrl
    import rvv_dispatch_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic      [NUM_DP_UOP-1:0] uop_valid,
    input  exe_unit_e [NUM_DP_UOP-1:0] uop_exe_unit,
    input  uop_class_e [NUM_DP_UOP-1:0] uop_class,
    input  vreg_idx_t [NUM_DP_UOP-1:0] uop_vs1,
    input  vreg_idx_t [NUM_DP_UOP-1:0] uop_vs2,
    input  vreg_idx_t [NUM_DP_UOP-1:0] uop_vd,
    input  logic      [NUM_DP_UOP-1:0] uop_vd_valid,
    input  logic      [NUM_DP_UOP-1:0] raw_hazard,
    input  logic                       strct_hazard,
    input  logic      [NUM_DP_UOP-1:0] rs_ready_alu,
    input  logic      [NUM_DP_UOP-1:0] rs_ready_mul,
    input  logic      [NUM_DP_UOP-1:0] rs_ready_lsu,
    input  logic      [NUM_DP_UOP-1:0] rob_push_ready,
    output logic      [NUM_DP_UOP-1:0] uop_ready,
    output logic      [NUM_DP_UOP-1:0] rs_valid_alu,
    output logic      [NUM_DP_UOP-1:0] rs_valid_mul,
    output logic      [NUM_DP_UOP-1:0] rs_valid_lsu,
    output logic      [NUM_DP_UOP-1:0] rob_push_valid
);

    logic [NUM_DP_UOP-1:0] rs_ready_sel;
    logic [NUM_DP_UOP-1:0] issue;
    logic                  raw_uu;

    // Ready of the station each uop targets
    for (genvar i = 0; i < NUM_DP_UOP; i++) begin : g_sel
        always_comb begin
            case (uop_exe_unit[i])
                EXE_ALU: rs_ready_sel[i] = rs_ready_alu[i];
                EXE_MUL: rs_ready_sel[i] = rs_ready_mul[i];
                EXE_LSU: rs_ready_sel[i] = rs_ready_lsu[i];
                default: rs_ready_sel[i] = 1'b0;
            endcase
        end
    end

    // Uop 1 reads the register uop 0 is about to write
    assign raw_uu = uop_vd_valid[0] &&
                    ((class_rd_vs1(uop_class[1]) && (uop_vs1[1] == uop_vd[0])) ||
                     (class_rd_vs2(uop_class[1]) && (uop_vs2[1] == uop_vd[0])) ||
                     (class_rd_vd(uop_class[1])  && (uop_vd[1]  == uop_vd[0])));

    assign issue[0] = uop_valid[0] && !raw_hazard[0] && rs_ready_sel[0] &&
                      rob_push_ready[0];

    // In order, so the younger uop only goes together with the older one
    assign issue[1] = issue[0] && uop_valid[1] && !raw_hazard[1] && !strct_hazard &&
                      !raw_uu && rs_ready_sel[1] && rob_push_ready[1];

    assign uop_ready      = issue;
    assign rob_push_valid = issue;

    for (genvar i = 0; i < NUM_DP_UOP; i++) begin : g_valid
        assign rs_valid_alu[i] = issue[i] && (uop_exe_unit[i] == EXE_ALU);
        assign rs_valid_mul[i] = issue[i] && (uop_exe_unit[i] == EXE_MUL);
        assign rs_valid_lsu[i] = issue[i] && (uop_exe_unit[i] == EXE_LSU);
    end

    a_in_order: assert property (@(posedge clk) disable iff (!rst_n)
        uop_ready[1] |-> uop_ready[0])
        else $error("uop 1 accepted without uop 0");

    a_one_station: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({rs_valid_alu[0], rs_valid_mul[0], rs_valid_lsu[0]}) &&
        $onehot0({rs_valid_alu[1], rs_valid_mul[1], rs_valid_lsu[1]}))
        else $error("uop sent to more than one reservation station");

    // Queue pop and ROB push stay in step
    a_rob_push: assert property (@(posedge clk) disable iff (!rst_n)
        rob_push_valid == uop_ready)
        else $error("ROB push does not match the uops taken from the queue");

endmodule

// File: src/rvv_dispatch_operand.sv
`timescale 1ns/100ps
// Operand source select for one dispatched uop
// Looks up the youngest ROB writer of every vector source the uop reads and
// returns either its completed result or the VRF data, and flags a RAW
// hazard when that writer has not finished yet

module rvv_dispatch_operand
    import rvv_dispatch_pkg::*;
#(
    parameter int VLEN      = 128,
    parameter int ROB_DEPTH = 8
) (
    input  uop_class_e                      uop_class,
    input  vreg_idx_t                       uop_vs1,
    input  vreg_idx_t                       uop_vs2,
    input  vreg_idx_t                       uop_vd,
    input  logic      [ROB_DEPTH-1:0]           rob_valid,
    input  vreg_idx_t [ROB_DEPTH-1:0]           rob_w_index,
    input  logic      [ROB_DEPTH-1:0]           rob_w_valid,
    input  logic      [ROB_DEPTH-1:0][VLEN-1:0] rob_w_data,
    input  logic      [VLEN-1:0]            vrf_vs1_data,
    input  logic      [VLEN-1:0]            vrf_vs2_data,
    input  logic      [VLEN-1:0]            vrf_vd_data,
    output logic                            raw_hazard,
    output logic      [VLEN-1:0]            vs1_data,
    output logic      [VLEN-1:0]            vs2_data,
    output logic      [VLEN-1:0]            vd_data
);

    // Source slots: 0 is vs2, 1 is vs1, 2 is vd
    localparam int NUM_SRC = 3;

    logic      [NUM_SRC-1:0]           src_rd;
    vreg_idx_t [NUM_SRC-1:0]           src_idx;
    logic      [NUM_SRC-1:0][VLEN-1:0] src_vrf;
    logic      [NUM_SRC-1:0]           src_pend;
    logic      [NUM_SRC-1:0][VLEN-1:0] src_data;

    assign src_rd  = {class_rd_vd(uop_class), class_rd_vs1(uop_class),
                      class_rd_vs2(uop_class)};
    assign src_idx = {uop_vd, uop_vs1, uop_vs2};
    assign src_vrf = {vrf_vd_data, vrf_vs1_data, vrf_vs2_data};

    for (genvar s = 0; s < NUM_SRC; s++) begin : g_src
        logic            hit;
        logic            pend;
        logic [VLEN-1:0] byp;

        // Entries are in age order, so the last match is the youngest writer
        always_comb begin
            hit  = 1'b0;
            pend = 1'b0;
            byp  = '0;
            for (int e = 0; e < ROB_DEPTH; e++) begin
                if (rob_valid[e] && (rob_w_index[e] == src_idx[s])) begin
                    hit  = 1'b1;
                    pend = !rob_w_valid[e];
                    byp  = rob_w_data[e];
                end
            end
        end

        assign src_pend[s] = hit && pend;
        // Completed writer forwards its result, otherwise the VRF copy is current
        assign src_data[s] = (hit && !pend) ? byp : src_vrf[s];
    end

    // Only sources the class actually reads can stall the uop
    assign raw_hazard = |(src_rd & src_pend);

    assign vs2_data = src_data[0];
    assign vs1_data = src_data[1];
    assign vd_data  = src_data[2];

    // A uop without vector sources never waits on the ROB
    always_comb begin
        if (uop_class == XXX) begin
            assert final (!raw_hazard)
                else $error("raw_hazard raised for a uop class with no vector sources");
        end
    end

endmodule

// File: src/rvv_dispatch_pkg.sv
// Shared definitions for the vector dual-issue dispatch stage
// Widths, register and opcode types, uop class and execution unit encodings,
// plus the decode of which vector sources a uop class reads

package rvv_dispatch_pkg;

    // Uops offered by the queue per cycle
    localparam int NUM_DP_UOP      = 2;
    // VRF read ports available to dispatch
    localparam int NUM_VRF_RD      = 4;
    localparam int REG_INDEX_WIDTH = 5;

    typedef logic [REG_INDEX_WIDTH-1:0] vreg_idx_t;
    typedef logic [5:0]                 funct_t;

    // Letters give vd (as vs3), vs1, vs2 in that order, V means read
    typedef enum logic [2:0] {
        VVV,
        XVV,
        VVX,
        VXX,
        XVX,
        XXV,
        XXX
    } uop_class_e;

    // Target reservation station
    typedef enum logic [1:0] {
        EXE_ALU,
        EXE_MUL,
        EXE_LSU
    } exe_unit_e;

    // Uop reads vd as a third source
    function automatic logic class_rd_vd(uop_class_e c);
        return c inside {VVV, VVX, VXX};
    endfunction

    // Uop reads vs1
    function automatic logic class_rd_vs1(uop_class_e c);
        return c inside {VVV, XVV, VVX, XVX};
    endfunction

    // Uop reads vs2
    function automatic logic class_rd_vs2(uop_class_e c);
        return c inside {VVV, XVV, XXV};
    endfunction

endpackage

// File: src/rvv_dispatch_vrf_read.sv
`timescale 1ns/100ps
// VRF read port allocation for the two dispatched uops
// Packs the sources of the older uop first, then the younger one, onto the
// read ports in vs2, vs1, vd order, steers the returned data back to each
// operand and flags a structure hazard when the ports run out

module rvv_dispatch_vrf_read
    import rvv_dispatch_pkg::*;
#(
    parameter int VLEN = 128
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  uop_class_e [NUM_DP_UOP-1:0]            uop_class,
    input  vreg_idx_t  [NUM_DP_UOP-1:0]            uop_vs1,
    input  vreg_idx_t  [NUM_DP_UOP-1:0]            uop_vs2,
    input  vreg_idx_t  [NUM_DP_UOP-1:0]            uop_vd,
    input  logic       [NUM_VRF_RD-1:0][VLEN-1:0]  vrf_rd_data,
    output vreg_idx_t  [NUM_VRF_RD-1:0]            vrf_rd_index,
    output logic                                   strct_hazard,
    output logic       [NUM_DP_UOP-1:0][VLEN-1:0]  vrf_vs1_data,
    output logic       [NUM_DP_UOP-1:0][VLEN-1:0]  vrf_vs2_data,
    output logic       [NUM_DP_UOP-1:0][VLEN-1:0]  vrf_vd_data
);

    // Source slots per uop: 0 is vs2, 1 is vs1, 2 is vd
    localparam int NUM_SRC = 3;
    localparam int PORT_W  = $clog2(NUM_VRF_RD);
    // Holds the read count of both uops together
    localparam int POS_W   = $clog2(NUM_DP_UOP * NUM_SRC + 1);

    logic      [NUM_DP_UOP-1:0][NUM_SRC-1:0]            src_rd;
    vreg_idx_t [NUM_DP_UOP-1:0][NUM_SRC-1:0]            src_idx;
    logic      [NUM_DP_UOP-1:0][NUM_SRC-1:0][POS_W-1:0] src_pos;
    logic      [NUM_DP_UOP-1:0][NUM_SRC-1:0][VLEN-1:0]  src_data;
    logic      [POS_W-1:0]                              rd_total;

    for (genvar i = 0; i < NUM_DP_UOP; i++) begin : g_uop
        assign src_rd[i]  = {class_rd_vd(uop_class[i]), class_rd_vs1(uop_class[i]),
                             class_rd_vs2(uop_class[i])};
        assign src_idx[i] = {uop_vd[i], uop_vs1[i], uop_vs2[i]};

        for (genvar s = 0; s < NUM_SRC; s++) begin : g_src
            // Slots that spill past the last port get no data
            assign src_data[i][s] = (src_pos[i][s] < POS_W'(NUM_VRF_RD)) ?
                                    vrf_rd_data[src_pos[i][s][PORT_W-1:0]] : '0;
        end

        assign vrf_vs2_data[i] = src_data[i][0];
        assign vrf_vs1_data[i] = src_data[i][1];
        assign vrf_vd_data[i]  = src_data[i][2];
    end

    // Running port count, older uop first
    // Reads are counted even if a ROB bypass later replaces the data
    always_comb begin
        logic [POS_W-1:0] pos;
        pos = '0;
        for (int i = 0; i < NUM_DP_UOP; i++) begin
            for (int s = 0; s < NUM_SRC; s++) begin
                src_pos[i][s] = pos;
                pos           = pos + POS_W'(src_rd[i][s]);
            end
        end
        rd_total = pos;
    end

    // Unused ports stay at register 0
    always_comb begin
        vrf_rd_index = '0;
        for (int i = 0; i < NUM_DP_UOP; i++) begin
            for (int s = 0; s < NUM_SRC; s++) begin
                if (src_rd[i][s] && (src_pos[i][s] < POS_W'(NUM_VRF_RD))) begin
                    vrf_rd_index[src_pos[i][s][PORT_W-1:0]] = src_idx[i][s];
                end
            end
        end
    end

    // Only the younger uop can run out of ports
    assign strct_hazard = rd_total > POS_W'(NUM_VRF_RD);

    // The older uop always fits, so it is never held back by the ports
    a_uop0_fits: assert property (@(posedge clk) disable iff (!rst_n)
        src_pos[1][0] < POS_W'(NUM_VRF_RD))
        else $error("uop 0 needs more VRF read ports than exist");

endmodule
